// ==== Makefile ====
# Verilator build of the bridge testbench, run target greps the output for the pass line

SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv) project.f

obj_dir/Vtb_top: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f project.f

run: obj_dir/Vtb_top
	obj_dir/Vtb_top | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== hw/bridge_params.svh ====
// shared widths, cycle counts and queue depth, included by the package and by RTL using them
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// one UART byte, also one half of an SPI frame
`define BYTE_W 8

// address byte plus data byte
`define SPI_FRAME_BITS 16

// system clocks per sck half period
`define SPI_HALF_PERIOD 4

// 66 MHz system clock over 115200 baud
`define UART_CLKS_PER_BIT 573

// readback bytes waiting for UART TX
`define RB_FIFO_DEPTH 4

// display reset stretch after global reset, in cycles
`define SLM_RESET_CYCLES 10

`endif

// ==== hw/bridge_pkg.sv ====
// state enums and packed bus structs shared by the bridge modules, compiled before any RTL
`include "bridge_params.svh"

package bridge_pkg;

  // bit phase of a UART frame, used by both directions
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // SPI master sequencing
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_SHIFT,
    SPI_FINISH
  } spi_state_e;

  // one command for the display config port
  typedef struct packed {
    logic              start;
    logic [`BYTE_W-1:0] addr;
    logic [`BYTE_W-1:0] data;
  } spi_req_t;

  // pins toward the display, sen is active low
  typedef struct packed {
    logic sen;
    logic sck;
    logic mosi;
  } spi_pins_t;

endpackage

// ==== hw/readback_queue.sv ====
// small FIFO of SPI readback bytes, drained one at a time into the UART transmitter
`timescale 1ns/10ps
`include "bridge_params.svh"

module readback_queue (
  input  logic               fpga_clk,
  input  logic               reset_all_cmd_w,
  input  logic [`BYTE_W-1:0] rb_byte_i,
  input  logic               rb_valid_i,
  input  logic               tx_active_i,
  output logic               tx_start_o,
  output logic [`BYTE_W-1:0] tx_byte_o
);

  localparam int PTR_W = $clog2(`RB_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`RB_FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`RB_FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(`RB_FIFO_DEPTH);

  logic [`BYTE_W-1:0] mem_q [`RB_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               tx_start_q;
  logic [`BYTE_W-1:0] tx_byte_q;
  logic               full_w;
  logic               empty_w;
  logic               push_w;
  logic               pop_w;

  // circular wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign full_w  = (count_q == CNT_FULL);
  assign empty_w = (count_q == '0);
  // readback lost when full
  assign push_w  = rb_valid_i && !full_w;
  // tx_active rises a cycle after the start strobe, so block on it too
  assign pop_w   = !empty_w && !tx_active_i && !tx_start_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_q <= 1'b0;
    end else begin
      // start follows the pop by one cycle
      tx_start_q <= pop_w;
      if (push_w) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_w) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and output byte
  always_ff @(posedge fpga_clk) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= rb_byte_i;
    end
    if (pop_w) begin
      tx_byte_q <= mem_q[rd_ptr_q];
    end
  end

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

endmodule

// ==== hw/slm_ctrl_top.sv ====
// board controller top, PC UART commands to the display SPI port with readback over UART TX
`timescale 1ns/10ps
`include "bridge_params.svh"

module slm_ctrl_top #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  output logic slm_reset_n_o
);
  import bridge_pkg::*;

  logic [`BYTE_W-1:0] rx_byte;
  logic               rx_valid;
  spi_req_t           spi_req;
  spi_pins_t          spi_pins;
  logic [`BYTE_W-1:0] rb_byte;
  logic               rb_valid;
  logic               tx_start;
  logic [`BYTE_W-1:0] tx_byte;
  logic               tx_active;

  //////////////////////////////
  // command path
  //////////////////////////////
  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_byte_o       (rx_byte),
    .rx_valid_o      (rx_valid)
  );

  spi_cmd_framer u_framer (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .rx_valid_i      (rx_valid),
    .spi_req_o       (spi_req)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_req_i       (spi_req),
    .miso_i          (spi_miso_i),
    .spi_pins_o      (spi_pins),
    .rb_byte_o       (rb_byte),
    .rb_valid_o      (rb_valid)
  );

  // struct out to display pins
  assign spi_sen_o  = spi_pins.sen;
  assign spi_sck_o  = spi_pins.sck;
  assign spi_mosi_o = spi_pins.mosi;

  //////////////////////////////
  // readback path
  //////////////////////////////
  readback_queue u_rb_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rb_byte_i       (rb_byte),
    .rb_valid_i      (rb_valid),
    .tx_active_i     (tx_active),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_serial_o     (uart_tx_o),
    .tx_active_o     (tx_active)
  );

  // display reset, separate from the chain
  slm_reset_gen u_slm_reset (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

// ==== hw/slm_reset_gen.sv ====
// holds the display's active-low reset for a fixed stretch after the global reset ends
`timescale 1ns/10ps
`include "bridge_params.svh"

module slm_reset_gen (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  localparam int CNT_W = $clog2(`SLM_RESET_CYCLES + 1);
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(`SLM_RESET_CYCLES);

  logic [CNT_W-1:0] count_q;

  // reload while global reset is high, count down after
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      count_q <= RELOAD;
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // display needs a minimum reset width, count covers it
  assign slm_reset_n_o = (count_q == '0);

endmodule

// ==== hw/spi_cmd_framer.sv ====
// pairs incoming UART bytes into address and data, one SPI request on every second byte
`timescale 1ns/10ps
`include "bridge_params.svh"

module spi_cmd_framer (
  input  logic                 fpga_clk,
  input  logic                 reset_all_cmd_w,
  input  logic [`BYTE_W-1:0]   rx_byte_i,
  input  logic                 rx_valid_i,
  output bridge_pkg::spi_req_t spi_req_o
);

  logic               odd_q;
  logic               start_q;
  logic [`BYTE_W-1:0] addr_q;
  logic [`BYTE_W-1:0] data_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // next byte is an address
      odd_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (rx_valid_i) begin
        // older byte moves up to address, new byte becomes data
        addr_q <= data_q;
        data_q <= rx_byte_i;
        odd_q  <= ~odd_q;
        // one byte already held, this one closes the pair
        start_q <= odd_q;
      end
    end
  end

  assign spi_req_o.start = start_q;
  assign spi_req_o.addr  = addr_q;
  assign spi_req_o.data  = data_q;

endmodule

// ==== hw/spi_master.sv ====
// mode-0 SPI master for the display config port, 16-bit frames, returns the last MISO byte
`timescale 1ns/10ps
`include "bridge_params.svh"

module spi_master (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  bridge_pkg::spi_req_t  spi_req_i,
  input  logic                  miso_i,
  output bridge_pkg::spi_pins_t spi_pins_o,
  output logic [`BYTE_W-1:0]    rb_byte_o,
  output logic                  rb_valid_o
);
  import bridge_pkg::*;

  localparam int DIV_W = $clog2(`SPI_HALF_PERIOD + 1);
  localparam int BIT_W = $clog2(`SPI_FRAME_BITS);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_HALF_PERIOD - 1);
  localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_FRAME_BITS - 1);

  spi_state_e                 state_q;
  logic [DIV_W-1:0]           div_q;
  logic [BIT_W-1:0]           bit_q;
  logic                       sen_q;
  logic                       sck_q;
  logic                       miso_q;
  logic                       rb_valid_q;
  logic [`SPI_FRAME_BITS-1:0] shift_q;
  logic [`BYTE_W-1:0]         rb_byte_q;
  logic                       half_done_w;

  // end of one sck half period
  assign half_done_w = (div_q == DIV_LAST);

  //////////////////////////////
  // frame sequencing
  //////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q    <= SPI_IDLE;
      div_q      <= '0;
      bit_q      <= '0;
      sen_q      <= 1'b1;
      sck_q      <= 1'b0;
      rb_valid_q <= 1'b0;
    end else begin
      rb_valid_q <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          // requests while busy never reach this branch
          if (spi_req_i.start) begin
            // address goes out first, MSB first
            shift_q <= {spi_req_i.addr, spi_req_i.data};
            sen_q   <= 1'b0;
            div_q   <= '0;
            bit_q   <= '0;
            state_q <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          div_q <= half_done_w ? '0 : div_q + 1'b1;
          if (half_done_w) begin
            sck_q <= ~sck_q;
            if (!sck_q) begin
              // rising edge, sample slave output
              miso_q <= miso_i;
            end else begin
              // falling edge, next bit out and sampled bit in
              shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], miso_q};
              bit_q   <= bit_q + 1'b1;
              if (bit_q == BIT_LAST) begin
                state_q <= SPI_FINISH;
              end
            end
          end
        end
        SPI_FINISH: begin
          // hold sen low one more half period
          div_q <= half_done_w ? '0 : div_q + 1'b1;
          if (half_done_w) begin
            sen_q      <= 1'b1;
            rb_valid_q <= 1'b1;
            // lower byte holds MISO from the data half
            rb_byte_q <= shift_q[`BYTE_W-1:0];
            state_q   <= SPI_IDLE;
          end
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  assign spi_pins_o.sen  = sen_q;
  assign spi_pins_o.sck  = sck_q;
  // mosi only meaningful while shifting
  assign spi_pins_o.mosi = (state_q == SPI_SHIFT) & shift_q[`SPI_FRAME_BITS-1];
  assign rb_byte_o       = rb_byte_q;
  assign rb_valid_o      = rb_valid_q;

endmodule

// ==== hw/uart_rx.sv ====
// PC UART receiver, samples each bit mid-period and strobes a finished byte for one cycle
`timescale 1ns/10ps
`include "bridge_params.svh"

module uart_rx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic               fpga_clk,
  input  logic               reset_all_cmd_w,
  input  logic               rx_serial_i,
  output logic [`BYTE_W-1:0] rx_byte_o,
  output logic               rx_valid_o
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`BYTE_W);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  // half a bit, lands the sampling point mid-bit
  localparam logic [CNT_W-1:0] MID_CNT = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`BYTE_W - 1);

  uart_state_e        state_q;
  logic [CNT_W-1:0]   clk_cnt_q;
  logic [IDX_W-1:0]   bit_idx_q;
  logic               rx_meta_q;
  logic               rx_sync_q;
  logic               valid_q;
  logic [`BYTE_W-1:0] shift_q;

  //////////////////////////////
  // input sync
  //////////////////////////////
  // two flops, line is async to fpga_clk
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////
  // bit phase FSM
  //////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      // strobe lasts a single cycle
      valid_q <= 1'b0;
      case (state_q)
        UART_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          // falling edge opens a frame
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt_q == MID_CNT) begin
            clk_cnt_q <= '0;
            // glitch shorter than half a bit, back to idle
            state_q <= rx_sync_q ? UART_IDLE : UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            // LSB arrives first, shift in from the top
            shift_q <= {rx_sync_q, shift_q[`BYTE_W-1:1]};
            if (bit_idx_q == LAST_IDX) begin
              state_q <= UART_STOP;
            end else begin
              bit_idx_q <= bit_idx_q + 1'b1;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            state_q   <= UART_IDLE;
            // framing error drops the byte
            valid_q <= rx_sync_q;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // shift_q is stable until well after the strobe
  assign rx_byte_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule

// ==== hw/uart_tx.sv ====
// PC UART transmitter, sends one byte per start strobe and flags activity until the stop bit ends
`timescale 1ns/10ps
`include "bridge_params.svh"

module uart_tx #(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  logic               fpga_clk,
  input  logic               reset_all_cmd_w,
  input  logic               tx_start_i,
  input  logic [`BYTE_W-1:0] tx_byte_i,
  output logic               tx_serial_o,
  output logic               tx_active_o
);
  import bridge_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int IDX_W = $clog2(`BYTE_W);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`BYTE_W - 1);

  uart_state_e        state_q;
  logic [CNT_W-1:0]   clk_cnt_q;
  logic [IDX_W-1:0]   bit_idx_q;
  logic               serial_q;
  logic [`BYTE_W-1:0] shift_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      serial_q  <= 1'b1;
    end else begin
      case (state_q)
        UART_IDLE: begin
          serial_q  <= 1'b1;
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (tx_start_i) begin
            // start bit shows on the very next cycle
            shift_q  <= tx_byte_i;
            serial_q <= 1'b0;
            state_q  <= UART_START;
          end
        end
        UART_START: begin
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            serial_q  <= shift_q[0];
            state_q   <= UART_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_DATA: begin
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            if (bit_idx_q == LAST_IDX) begin
              serial_q <= 1'b1;
              state_q  <= UART_STOP;
            end else begin
              // LSB first, next bit drops into position 0
              bit_idx_q <= bit_idx_q + 1'b1;
              serial_q  <= shift_q[1];
              shift_q   <= {1'b0, shift_q[`BYTE_W-1:1]};
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        UART_STOP: begin
          // full stop bit before going idle
          if (clk_cnt_q == LAST_CNT) begin
            clk_cnt_q <= '0;
            state_q   <= UART_IDLE;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  assign tx_serial_o = serial_q;
  // busy from start bit through end of stop bit
  assign tx_active_o = (state_q != UART_IDLE);

endmodule

// ==== project.f ====
+incdir+hw
hw/bridge_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/spi_cmd_framer.sv
hw/spi_master.sv
hw/readback_queue.sv
hw/slm_reset_gen.sv
hw/slm_ctrl_top.sv
tests/bridge_checker.sv
tests/tb_top.sv

// ==== tests/bridge_checker.sv ====
// pin-level protocol assertions, bound into the bridge top level by the bind at the bottom
`timescale 1ns/10ps

module bridge_checker (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic sen_i,
  input logic sck_i,
  input logic uart_tx_i,
  input logic slm_reset_n_i
);

  // count of failed assertions
  int unsigned violations = 0;

  //////////////////////////////
  // SPI pins
  //////////////////////////////
  // mode 0, sck parks low outside a frame
  sck_low_while_closed: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sen_i |-> !sck_i
  ) else begin
    $error("sck high while sen is high");
    violations++;
  end

  //////////////////////////////
  // reset release
  //////////////////////////////
  // first cycle out of reset, both links idle
  idle_after_reset: assert property (
    @(posedge fpga_clk) $fell(reset_all_cmd_w) |-> (uart_tx_i && sen_i)
  ) else begin
    $error("uart_tx or sen not idle high after reset");
    violations++;
  end

  // display reset still held when global reset lets go
  display_held_at_release: assert property (
    @(posedge fpga_clk) $fell(reset_all_cmd_w) |-> !slm_reset_n_i
  ) else begin
    $error("display reset released together with global reset");
    violations++;
  end

  // global reset reloads the stretch counter
  display_held_in_reset: assert property (
    @(posedge fpga_clk) reset_all_cmd_w |=> !slm_reset_n_i
  ) else begin
    $error("display reset high during global reset");
    violations++;
  end

endmodule

bind slm_ctrl_top bridge_checker u_bridge_checker (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (spi_sen_o),
  .sck_i           (spi_sck_o),
  .uart_tx_i       (uart_tx_o),
  .slm_reset_n_i   (slm_reset_n_o)
);

// ==== tests/tb_top.sv ====
// testbench for the UART to SPI bridge, sends PC bytes, models the display SPI slave, checks readback
`timescale 1ns/10ps
`include "bridge_params.svh"

module tb_top;

  localparam int CLKS_PER_BIT = 16;
  // 12 bytes in, 6 readback bytes out
  localparam int UART_BYTES   = 18;
  localparam int MARGIN       = 4;
  localparam int CYCLE_LIMIT  = UART_BYTES * 10 * CLKS_PER_BIT * MARGIN;

  logic fpga_clk = 1'b0;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sen_o;
  logic spi_sck_o;
  logic spi_mosi_o;
  logic spi_miso_i;
  logic slm_reset_n_o;

  // scoreboard
  logic [15:0]        frame_q[$];
  logic [`BYTE_W-1:0] rb_sent_q[$];
  logic [`BYTE_W-1:0] tx_seen_q[$];
  int                 sen_falls = 0;
  int unsigned        cycles = 0;
  logic [15:0]        lfsr_q = 16'd25154;

  slm_ctrl_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) dut0 (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  // 100 ns period
  always #50 fpga_clk = ~fpga_clk;

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic expect_value(input string what, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else
      fail_run($sformatf("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one step per bit taken
  task automatic random_byte(output logic [`BYTE_W-1:0] b);
    b = '0;
    for (int i = 0; i < `BYTE_W; i++) begin
      b = {b[`BYTE_W-2:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic drive_bit(input logic v);
    @(negedge fpga_clk);
    uart_rx_i <= v;
    repeat (CLKS_PER_BIT - 1) @(negedge fpga_clk);
  endtask

  // start, 8 data LSB first, stop, one idle bit
  task automatic send_byte(input logic [`BYTE_W-1:0] b);
    drive_bit(1'b0);
    for (int i = 0; i < `BYTE_W; i++) begin
      drive_bit(b[i]);
    end
    drive_bit(1'b1);
    drive_bit(1'b1);
  endtask

  task automatic wait_frames(input int n);
    while (frame_q.size() < n) @(negedge fpga_clk);
  endtask

  task automatic wait_readbacks(input int n);
    while (tx_seen_q.size() < n) @(negedge fpga_clk);
  endtask

  // frame idx carries {a, d}, its slave byte came back on uart_tx
  task automatic check_pair(input int idx, input logic [`BYTE_W-1:0] a,
                            input logic [`BYTE_W-1:0] d);
    wait_frames(idx + 1);
    expect_value("SPI frame", frame_q[idx], {a, d});
    wait_readbacks(idx + 1);
    expect_value("readback byte", 16'(tx_seen_q[idx]), 16'(rb_sent_q[idx]));
  endtask

  //////////////////////////////
  // timeout
  //////////////////////////////
  always @(posedge fpga_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT));
    end
  end

  // bound pin assertions
  always @(negedge fpga_clk) begin
    if (dut0.u_bridge_checker.violations != 0) begin
      fail_run("bound checker reported a failed assertion");
    end
  end

  //////////////////////////////
  // SPI slave model
  //////////////////////////////
  logic [15:0]        slv_shift = '0;
  logic [`BYTE_W-1:0] slv_rb = '0;
  int                 slv_bits = 0;
  logic               prev_sen = 1'b1;
  logic               prev_sck = 1'b0;

  // pins sampled mid-cycle, edges found against last sample
  always @(negedge fpga_clk) begin
    if (!reset_all_cmd_w) begin
      if (!spi_sen_o && prev_sen) begin
        sen_falls++;
        slv_bits = 0;
        random_byte(slv_rb);
      end
      if (!spi_sen_o && spi_sck_o && !prev_sck) begin
        slv_shift = {slv_shift[14:0], spi_mosi_o};
        slv_bits++;
      end
      if (spi_sen_o && !prev_sen) begin
        expect_value("SPI bit count", 16'(slv_bits), 16'd16);
        frame_q.push_back(slv_shift);
        rb_sent_q.push_back(slv_rb);
      end
      // data half returns the chosen byte MSB first
      if (slv_bits >= 8 && slv_bits < 16) begin
        spi_miso_i <= slv_rb[15 - slv_bits];
      end else begin
        spi_miso_i <= 1'b0;
      end
      prev_sen = spi_sen_o;
      prev_sck = spi_sck_o;
    end
  end

  //////////////////////////////
  // UART TX monitor
  //////////////////////////////
  initial begin : uart_monitor
    logic [`BYTE_W-1:0] b;
    @(negedge reset_all_cmd_w);
    forever begin
      @(negedge fpga_clk);
      if (uart_tx_o == 1'b0) begin
        // move to mid start bit
        repeat (CLKS_PER_BIT / 2) @(negedge fpga_clk);
        expect_value("uart_tx start bit", 16'(uart_tx_o), 16'd0);
        for (int i = 0; i < `BYTE_W; i++) begin
          repeat (CLKS_PER_BIT) @(negedge fpga_clk);
          b[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge fpga_clk);
        expect_value("uart_tx stop bit", 16'(uart_tx_o), 16'd1);
        tx_seen_q.push_back(b);
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin : stimulus
    logic [`BYTE_W-1:0] a;
    logic [`BYTE_W-1:0] d;
    logic [`BYTE_W-1:0] burst [8];
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    spi_miso_i      = 1'b0;
    repeat (2) @(negedge fpga_clk);
    reset_all_cmd_w <= 1'b0;

    // display reset counts out after release
    expect_value("slm_reset_n_o at release", 16'(slm_reset_n_o), 16'd0);
    for (int i = 1; i <= `SLM_RESET_CYCLES; i++) begin
      @(negedge fpga_clk);
      expect_value("slm_reset_n_o", 16'(slm_reset_n_o), 16'(i == `SLM_RESET_CYCLES));
      expect_value("spi_sen_o idle", 16'(spi_sen_o), 16'd1);
      expect_value("uart_tx_o idle", 16'(uart_tx_o), 16'd1);
    end

    // one pair, one frame
    random_byte(a);
    random_byte(d);
    send_byte(a);
    send_byte(d);
    check_pair(0, a, d);
    expect_value("frames after first pair", 16'(sen_falls), 16'd1);

    // odd byte alone starts nothing, then becomes the address
    random_byte(a);
    send_byte(a);
    expect_value("frames after odd byte", 16'(sen_falls), 16'd1);
    random_byte(d);
    send_byte(d);
    check_pair(1, a, d);

    // four pairs back to back
    for (int i = 0; i < 8; i++) begin
      random_byte(burst[i]);
    end
    for (int i = 0; i < 8; i++) begin
      send_byte(burst[i]);
    end
    for (int i = 0; i < 4; i++) begin
      check_pair(2 + i, burst[2 * i], burst[2 * i + 1]);
    end
    expect_value("total frames", 16'(sen_falls), 16'd6);
    expect_value("total readbacks", 16'(tx_seen_q.size()), 16'd6);

    if (dut0.u_bridge_checker.violations == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("bound checker reported failed assertions");
    end
  end

endmodule
